//--- vlog.f
source/csr_pkg.sv
source/csr_access_ctrl.sv
source/csr_counter.sv
source/csr_trap_regs.sv
source/csr_read_mux.sv
source/csr_unit.sv
testbench/csr_tb.sv

//--- Makefile
# Verilator flow for the CSR unit

VERILATOR ?= verilator
TOP       ?= csr_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/csr_tb.sv
`timescale 1ns/1ps

module csr_tb import csr_pkg::*; ();

    localparam int period          = 4;
    localparam int hart_id_val     = 7;
    localparam int mtvec_align_val = 6;
    localparam int num_rand_writes = 12;
    localparam int irq_cycles      = 8;
    localparam int num_addrs       = 19;
    // rough step count of all tests below plus slack
    localparam int test_cycles = 3 + 2 * num_addrs + 2 * num_rand_writes + 4 * irq_cycles + 60;
    localparam int margin_ns   = 100;

    localparam csr_addr_t all_addrs [num_addrs] = '{
        csr_addr_cycle, csr_addr_cycleh, csr_addr_instret, csr_addr_instreth,
        csr_addr_mcycle, csr_addr_mcycleh, csr_addr_minstret, csr_addr_minstreth,
        csr_addr_mhartid, csr_addr_mstatus, csr_addr_mstatush, csr_addr_mtvec,
        csr_addr_mip, csr_addr_mie, csr_addr_mcountinhibit, csr_addr_mscratch,
        csr_addr_mepc, csr_addr_mcause, csr_addr_mtval
    };

    localparam csr_addr_t rw_addrs [7] = '{
        csr_addr_mscratch, csr_addr_mcause, csr_addr_mtval, csr_addr_mie,
        csr_addr_mstatus, csr_addr_mtvec, csr_addr_mepc
    };

    logic       clk;
    logic       rst_n;
    csr_req_t   req;
    trap_req_t  trap;
    logic       stall_exec;
    logic       bubble_exec;
    logic       mtime_interrupt;
    xlen_word_t int_sources;
    xlen_word_t rd_data;
    logic       addr_is_illegal;
    xlen_word_t mepc;
    xlen_word_t mtvec;
    xlen_word_t interrupts;

    // reference model state
    logic [1:0]  m_priv;
    logic        m_st_mprv;
    logic [1:0]  m_st_mpp;
    logic        m_st_mpie;
    logic        m_st_mie;
    xlen_word_t  m_mtvec;
    xlen_word_t  m_mepc;
    xlen_word_t  m_mscratch;
    xlen_word_t  m_mcause;
    xlen_word_t  m_mtval;
    logic [15:0] m_mie_hi;
    logic        m_mie_mti;
    logic        m_inh_cy;
    logic        m_inh_ir;
    counter_t    m_cycle;
    counter_t    m_instret;

    int         errors = 0;
    int         checks = 0;
    logic       checking = 1'b0;
    string      test_name = "reset";
    xlen_word_t lcg_state = 32'd6242;

    csr_unit #(
        .hart_id     (hart_id_val),
        .mtvec_align (mtvec_align_val)
    ) dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .trap            (trap),
        .stall_exec      (stall_exec),
        .bubble_exec     (bubble_exec),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .rd_data         (rd_data),
        .addr_is_illegal (addr_is_illegal),
        .mepc            (mepc),
        .mtvec           (mtvec),
        .interrupts      (interrupts)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    function automatic xlen_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model
    function automatic logic addr_legal(input csr_addr_t addr);
        case (addr)
            csr_addr_cycle, csr_addr_cycleh, csr_addr_instret, csr_addr_instreth:
                return 1'b1;
            csr_addr_mcycle, csr_addr_mcycleh, csr_addr_minstret, csr_addr_minstreth,
            csr_addr_mhartid, csr_addr_mstatus, csr_addr_mstatush, csr_addr_mtvec,
            csr_addr_mip, csr_addr_mie, csr_addr_mcountinhibit, csr_addr_mscratch,
            csr_addr_mepc, csr_addr_mcause, csr_addr_mtval:
                return m_priv == 2'd3;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic xlen_word_t legal_mtvec(input xlen_word_t d);
        xlen_word_t v;
        v = {d[31:2], 2'b00};
        if (d[1:0] == 2'b01) begin
            v = d;
            for (int b = 2; b < mtvec_align_val; b++)
                v[b] = 1'b0;
        end
        return v;
    endfunction

    function automatic xlen_word_t model_mstatus();
        xlen_word_t w;
        w     = '0;
        w[17] = m_st_mprv;
        w[12:11] = m_st_mpp;
        w[7]  = m_st_mpie;
        w[3]  = m_st_mie;
        return w;
    endfunction

    function automatic xlen_word_t model_mie();
        xlen_word_t w;
        w        = '0;
        w[31:16] = m_mie_hi;
        w[7]     = m_mie_mti;
        return w;
    endfunction

    function automatic xlen_word_t model_mip();
        xlen_word_t w;
        w        = '0;
        w[31:16] = int_sources[31:16];
        w[7]     = mtime_interrupt;
        return w;
    endfunction

    // expected {illegal, rd_data} for a request against the model state
    function automatic logic [32:0] ref_read(input csr_req_t r);
        xlen_word_t value;
        logic       legal;
        legal = addr_legal(r.rd_addr);
        value = '0;
        case (r.rd_addr)
            csr_addr_cycle, csr_addr_mcycle:       value = m_cycle[31:0];
            csr_addr_cycleh, csr_addr_mcycleh:     value = m_cycle[63:32];
            csr_addr_instret, csr_addr_minstret:   value = m_instret[31:0];
            csr_addr_instreth, csr_addr_minstreth: value = m_instret[63:32];
            csr_addr_mhartid:  value = 32'(hart_id_val);
            csr_addr_mstatus:  value = model_mstatus();
            csr_addr_mtvec:    value = m_mtvec;
            csr_addr_mip:      value = model_mip();
            csr_addr_mie:      value = model_mie();
            csr_addr_mscratch: value = m_mscratch;
            csr_addr_mepc:     value = m_mepc;
            csr_addr_mcause:   value = m_mcause;
            csr_addr_mtval:    value = m_mtval;
            csr_addr_mcountinhibit: begin
                value[0] = m_inh_cy;
                value[2] = m_inh_ir;
            end
            default: value = '0;
        endcase
        if (!legal) begin
            value = '0;
        end
        if (r.wr_en && r.wr_addr == r.rd_addr) begin
            value = r.wr_data;
        end
        return {!legal, value};
    endfunction

    function automatic xlen_word_t ref_interrupts();
        if (!rst_n) begin
            return '0;
        end
        // machine mode needs MIE while user mode takes them regardless
        if (m_priv == 2'd3 && !m_st_mie) begin
            return '0;
        end
        return model_mie() & model_mip();
    endfunction

    always @(posedge clk) begin : model_update
        logic       commit;
        logic       retire;
        xlen_word_t d;
        commit = req.wr_en && !stall_exec && !bubble_exec && addr_legal(req.wr_addr);
        retire = !stall_exec && !bubble_exec;
        d      = req.wr_data;
        if (!rst_n) begin
            m_priv     <= 2'd3;
            m_st_mprv  <= 1'b0;
            m_st_mpp   <= 2'd0;
            m_st_mpie  <= 1'b1;
            m_st_mie   <= 1'b1;
            m_mtvec    <= '0;
            m_mepc     <= '0;
            m_mscratch <= '0;
            m_mcause   <= '0;
            m_mtval    <= '0;
            m_mie_hi   <= '0;
            m_mie_mti  <= 1'b0;
            m_inh_cy   <= 1'b0;
            m_inh_ir   <= 1'b0;
            m_cycle    <= '0;
            m_instret  <= '0;
        end else begin
            if (commit && req.wr_addr == csr_addr_mcycle) begin
                m_cycle[31:0] <= d;
            end else if (commit && req.wr_addr == csr_addr_mcycleh) begin
                m_cycle[63:32] <= d;
            end else if (!m_inh_cy) begin
                m_cycle <= m_cycle + 64'd1;
            end
            if (commit && req.wr_addr == csr_addr_minstret) begin
                m_instret[31:0] <= d;
            end else if (commit && req.wr_addr == csr_addr_minstreth) begin
                m_instret[63:32] <= d;
            end else if (!m_inh_ir && retire) begin
                m_instret <= m_instret + 64'd1;
            end
            if (commit && req.wr_addr == csr_addr_mcountinhibit) begin
                m_inh_cy <= d[0];
                m_inh_ir <= d[2];
            end
            if (trap.insert && trap.is_mret) begin
                m_priv    <= m_st_mpp;
                m_st_mie  <= m_st_mpie;
                m_st_mpie <= 1'b1;
                m_st_mpp  <= 2'd0;
                if (m_st_mpp != 2'd3) begin
                    m_st_mprv <= 1'b0;
                end
            end else if (trap.insert) begin
                m_st_mpie <= m_st_mie;
                m_st_mie  <= 1'b0;
                m_st_mpp  <= m_priv;
                m_mepc    <= trap.epc;
                m_mcause  <= trap.cause;
                m_mtval   <= trap.val;
            end else if (commit) begin
                case (req.wr_addr)
                    csr_addr_mstatus: begin
                        m_st_mprv <= d[17];
                        m_st_mpp  <= (d[12:11] == 2'b11) ? 2'd3 : 2'd0;
                        m_st_mpie <= d[7];
                        m_st_mie  <= d[3];
                    end
                    csr_addr_mie: begin
                        m_mie_hi  <= d[31:16];
                        m_mie_mti <= d[7];
                    end
                    csr_addr_mtvec:    m_mtvec    <= legal_mtvec(d);
                    csr_addr_mscratch: m_mscratch <= d;
                    csr_addr_mepc:     m_mepc     <= {d[31:2], 2'b00};
                    csr_addr_mcause:   m_mcause   <= d;
                    csr_addr_mtval:    m_mtval    <= d;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checking
    task automatic check(input string name, input xlen_word_t expected,
                         input xlen_word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error %s: expected %h, actual %h at %0t ns", name, expected, actual,
                     $time);
        end
    endtask

    // compare just before the next edge
    initial begin : compare_proc
        logic [32:0] exp_rd;
        forever begin
            @(posedge clk);
            #3;
            if (checking) begin
                exp_rd = ref_read(req);
                check({test_name, " rd_data"}, exp_rd[31:0], rd_data);
                check({test_name, " addr_is_illegal"}, {31'b0, exp_rd[32]},
                      {31'b0, addr_is_illegal});
                check({test_name, " interrupts"}, ref_interrupts(), interrupts);
                check({test_name, " mepc"}, m_mepc, mepc);
                check({test_name, " mtvec"}, m_mtvec, mtvec);
            end
        end
    end

    initial begin : watchdog
        #(test_cycles * period + margin_ns);
        $display("timeout: tests did not finish within %0d ns", test_cycles * period + margin_ns);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic read_csr(input csr_addr_t addr);
        req.wr_en   = 1'b0;
        req.rd_addr = addr;
        step();
    endtask

    // write cycle reads the same address for the bypass and then reads back
    task automatic write_csr(input csr_addr_t addr, input xlen_word_t data);
        req.wr_en   = 1'b1;
        req.wr_addr = addr;
        req.wr_data = data;
        req.rd_addr = addr;
        step();
        read_csr(addr);
    endtask

    task automatic read_all();
        for (int i = 0; i < num_addrs; i++)
            read_csr(all_addrs[i]);
    endtask

    task automatic drive_irq_sources(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            int_sources     = lcg_next();
            mtime_interrupt = lcg_next() > 32'h8000_0000;
            req.rd_addr     = csr_addr_mip;
            step();
        end
    endtask

    initial begin : stimulus
        rst_n           = 1'b0;
        req             = '0;
        trap            = '0;
        stall_exec      = 1'b0;
        bubble_exec     = 1'b0;
        mtime_interrupt = 1'b0;
        int_sources     = '0;
        req.rd_addr     = csr_addr_mstatus;
        step();
        checking = 1'b1;
        step();
        step();

        // reset mstatus has MIE and MPIE set and MPP user
        check("reset mstatus", 32'h0000_0088, rd_data);
        rst_n = 1'b1;
        read_all();

        test_name = "write";
        for (int i = 0; i < num_rand_writes; i++) begin
            write_csr(rw_addrs[i % 7], lcg_next());
        end
        // vectored and reserved mtvec modes, mepc with both low bits set
        write_csr(csr_addr_mtvec, (lcg_next() & 32'hFFFF_FFFC) | 32'h1);
        write_csr(csr_addr_mtvec, lcg_next() | 32'h3);
        write_csr(csr_addr_mepc, lcg_next() | 32'h3);
        test_name  = "stall";
        stall_exec = 1'b1;
        write_csr(csr_addr_mscratch, lcg_next());
        stall_exec  = 1'b0;
        bubble_exec = 1'b1;
        write_csr(csr_addr_mcause, lcg_next());
        bubble_exec = 1'b0;

        test_name = "counters";
        write_csr(csr_addr_mcountinhibit, 32'h5);
        write_csr(csr_addr_mcycle, lcg_next());
        write_csr(csr_addr_mcycleh, lcg_next());
        write_csr(csr_addr_minstret, lcg_next());
        write_csr(csr_addr_minstreth, lcg_next());
        read_csr(csr_addr_cycle);
        read_csr(csr_addr_cycleh);
        read_csr(csr_addr_instret);
        read_csr(csr_addr_instreth);
        write_csr(csr_addr_mcountinhibit, 32'h1);
        stall_exec = 1'b1;
        repeat (4) read_csr(csr_addr_minstret);
        stall_exec = 1'b0;
        read_csr(csr_addr_instret);
        read_csr(csr_addr_instret);
        write_csr(csr_addr_mcountinhibit, 32'h0);

        test_name = "irq_machine";
        write_csr(csr_addr_mie, 32'hFFFF_0080);
        write_csr(csr_addr_mstatus, 32'h0000_0088);
        drive_irq_sources(irq_cycles);
        write_csr(csr_addr_mstatus, 32'h0000_0080);
        drive_irq_sources(irq_cycles);

        test_name   = "trap";
        trap.insert = 1'b1;
        trap.epc    = lcg_next();
        trap.cause  = lcg_next();
        trap.val    = lcg_next();
        step();
        trap = '0;
        read_csr(csr_addr_mepc);
        read_csr(csr_addr_mcause);
        read_csr(csr_addr_mtval);
        read_csr(csr_addr_mstatus);
        // MPP user and MPIE clear so MIE stays low after mret
        write_csr(csr_addr_mstatus, 32'h0);
        trap.insert  = 1'b1;
        trap.is_mret = 1'b1;
        step();
        trap = '0;
        test_name = "user_mode";
        read_all();
        read_csr(12'h7C0);
        write_csr(csr_addr_mscratch, lcg_next());

        test_name = "irq_user";
        drive_irq_sources(irq_cycles);

        checking = 1'b0;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- source/csr_unit.sv
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; #(
    parameter int hart_id     = 0,
    parameter int mtvec_align = 6
) (
    input  logic       clk,
    input  logic       rst_n,
    input  csr_req_t   req,
    input  trap_req_t  trap,
    input  logic       stall_exec,
    input  logic       bubble_exec,
    input  logic       mtime_interrupt,
    input  xlen_word_t int_sources,
    output xlen_word_t rd_data,
    output logic       addr_is_illegal,
    output xlen_word_t mepc,
    output xlen_word_t mtvec,
    output xlen_word_t interrupts
);

    csr_sel_t                        rd_sel;
    csr_target_e                     wr_target;
    logic                            commit;
    counter_ctl_t [num_counters-1:0] counter_ctl;
    counter_t     [num_counters-1:0] counts;
    xlen_word_t                      mcountinhibit_q;
    priv_mode_e                      priv;
    mregs_t                          mregs;

    csr_access_ctrl access_ctrl0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (req),
        .stall_exec      (stall_exec),
        .bubble_exec     (bubble_exec),
        .priv            (priv),
        .rd_sel          (rd_sel),
        .wr_target       (wr_target),
        .commit          (commit),
        .counter_ctl     (counter_ctl),
        .mcountinhibit_q (mcountinhibit_q)
    );

    // one counter per performance event
    for (genvar i = 0; i < num_counters; i++) begin : g_counter
        csr_counter counter0 (
            .clk     (clk),
            .rst_n   (rst_n),
            .ctl     (counter_ctl[i]),
            .wr_data (req.wr_data),
            .count   (counts[i])
        );
    end

    csr_trap_regs #(
        .mtvec_align (mtvec_align)
    ) trap_regs0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .commit          (commit),
        .wr_target       (wr_target),
        .wr_data         (req.wr_data),
        .trap            (trap),
        .mtime_interrupt (mtime_interrupt),
        .int_sources     (int_sources),
        .priv            (priv),
        .mregs           (mregs),
        .mepc            (mepc),
        .mtvec           (mtvec),
        .interrupts      (interrupts)
    );

    csr_read_mux #(
        .hart_id (hart_id)
    ) read_mux0 (
        .rd_sel          (rd_sel),
        .req             (req),
        .counts          (counts),
        .mregs           (mregs),
        .mcountinhibit_q (mcountinhibit_q),
        .rd_data         (rd_data),
        .addr_is_illegal (addr_is_illegal)
    );

endmodule

//--- source/csr_read_mux.sv
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; #(
    parameter int hart_id = 0
) (
    input  csr_sel_t                     rd_sel,
    input  csr_req_t                     req,
    input  counter_t [num_counters-1:0]  counts,
    input  mregs_t                       mregs,
    input  xlen_word_t                   mcountinhibit_q,
    output xlen_word_t                   rd_data,
    output logic                         addr_is_illegal
);

    xlen_word_t selected;
    xlen_word_t masked;
    logic       bypass;

    ////////////////////////////////////////////////////////////
    // target select
    always_comb begin
        case (rd_sel.target)
            // user aliases share the machine counters
            tgt_cycle, tgt_mcycle:         selected = counts[ctr_cycle][31:0];
            tgt_cycleh, tgt_mcycleh:       selected = counts[ctr_cycle][63:32];
            tgt_instret, tgt_minstret:     selected = counts[ctr_instret][31:0];
            tgt_instreth, tgt_minstreth:   selected = counts[ctr_instret][63:32];
            tgt_mhartid:                   selected = xlen_word_t'(hart_id);
            tgt_mstatus:                   selected = mregs.mstatus;
            tgt_mtvec:                     selected = mregs.mtvec;
            tgt_mip:                       selected = mregs.mip;
            tgt_mie:                       selected = mregs.mie;
            tgt_mcountinhibit:             selected = mcountinhibit_q;
            tgt_mscratch:                  selected = mregs.mscratch;
            tgt_mepc:                      selected = mregs.mepc;
            tgt_mcause:                    selected = mregs.mcause;
            tgt_mtval:                     selected = mregs.mtval;
            // mstatush has no implemented fields
            default:                       selected = '0;
        endcase
    end

    assign masked          = rd_sel.legal ? selected : '0;
    assign addr_is_illegal = !rd_sel.legal;

    // same-address write shows through in this cycle
    assign bypass  = req.wr_en && (req.wr_addr == req.rd_addr);
    assign rd_data = bypass ? req.wr_data : masked;

endmodule

//--- source/csr_trap_regs.sv
`timescale 1ns/1ps

module csr_trap_regs import csr_pkg::*; #(
    parameter int mtvec_align = 6
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        commit,
    input  csr_target_e wr_target,
    input  xlen_word_t  wr_data,
    input  trap_req_t   trap,
    input  logic        mtime_interrupt,
    input  xlen_word_t  int_sources,
    output priv_mode_e  priv,
    output mregs_t      mregs,
    output xlen_word_t  mepc,
    output xlen_word_t  mtvec,
    output xlen_word_t  interrupts
);

    // bits mtvec_align-1 down to 2 of a vectored base
    localparam xlen_word_t vec_mask = ((32'd1 << mtvec_align) - 32'd1) & ~32'd3;

    logic        mstatus_mprv;
    priv_mode_e  mstatus_mpp;
    logic        mstatus_mpie;
    logic        mstatus_mie;
    logic [15:0] mie_ext;
    logic        mie_mti;
    xlen_word_t  mscratch;
    xlen_word_t  mcause;
    xlen_word_t  mtval;
    xlen_word_t  mie_word;
    xlen_word_t  mip_word;

    ////////////////////////////////////////////////////////////
    // register updates, trap and mret win over CSR writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv         <= priv_machine;
            mstatus_mprv <= 1'b0;
            mstatus_mpp  <= priv_user;
            mstatus_mpie <= 1'b1;
            mstatus_mie  <= 1'b1;
            mie_ext      <= '0;
            mie_mti      <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
            mscratch     <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (trap.insert && trap.is_mret) begin
            priv         <= mstatus_mpp;
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= priv_user;
            if (mstatus_mpp != priv_machine) begin
                mstatus_mprv <= 1'b0;
            end
        end else if (trap.insert) begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mstatus_mpp  <= priv;
            mepc         <= trap.epc;
            mcause       <= trap.cause;
            mtval        <= trap.val;
        end else if (commit) begin
            case (wr_target)
                tgt_mstatus: begin
                    mstatus_mprv <= wr_data[17];
                    // only user and machine exist, other codes fall back to user
                    mstatus_mpp  <= (wr_data[12:11] == 2'b11) ? priv_machine : priv_user;
                    mstatus_mpie <= wr_data[7];
                    mstatus_mie  <= wr_data[3];
                end
                tgt_mtvec: begin
                    if (wr_data[1:0] == mtvec_mode_vectored) begin
                        mtvec <= wr_data & ~vec_mask;
                    end else begin
                        mtvec <= {wr_data[31:2], mtvec_mode_direct};
                    end
                end
                tgt_mie: begin
                    mie_ext <= wr_data[31:16];
                    mie_mti <= wr_data[7];
                end
                tgt_mscratch: mscratch <= wr_data;
                tgt_mepc:     mepc     <= {wr_data[31:2], 2'b00};
                tgt_mcause:   mcause   <= wr_data;
                tgt_mtval:    mtval    <= wr_data;
                default: begin
                    // read-only or held elsewhere
                end
            endcase
        end
    end

    // platform sources in the upper half, timer at MTI
    assign mip_word = {int_sources[31:16], 8'b0, mtime_interrupt, 7'b0};
    assign mie_word = {mie_ext, 8'b0, mie_mti, 7'b0};

    assign mregs.mstatus  = {14'b0, mstatus_mprv, 4'b0, mstatus_mpp, 3'b0,
                             mstatus_mpie, 3'b0, mstatus_mie, 3'b0};
    assign mregs.mtvec    = mtvec;
    assign mregs.mip      = mip_word;
    assign mregs.mie      = mie_word;
    assign mregs.mscratch = mscratch;
    assign mregs.mepc     = mepc;
    assign mregs.mcause   = mcause;
    assign mregs.mtval    = mtval;

    ////////////////////////////////////////////////////////////
    // interrupt masking
    always_comb begin
        if (!rst_n) begin
            interrupts = '0;
        end else if (priv == priv_machine) begin
            interrupts = mstatus_mie ? (mie_word & mip_word) : '0;
        end else begin
            // lower privilege always takes enabled machine interrupts
            interrupts = mie_word & mip_word;
        end
    end

endmodule

//--- source/csr_counter.sv
`timescale 1ns/1ps

module csr_counter import csr_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  counter_ctl_t ctl,
    input  xlen_word_t   wr_data,
    output counter_t     count
);

    // a half write wins over the increment in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (ctl.wr_lo) begin
            count[31:0] <= wr_data;
        end else if (ctl.wr_hi) begin
            count[63:32] <= wr_data;
        end else if (ctl.inc) begin
            count <= count + 64'd1;
        end
    end

endmodule

//--- source/csr_access_ctrl.sv
`timescale 1ns/1ps

module csr_access_ctrl import csr_pkg::*; (
    input  logic                             clk,
    input  logic                             rst_n,
    input  csr_req_t                         req,
    input  logic                             stall_exec,
    input  logic                             bubble_exec,
    input  priv_mode_e                       priv,
    output csr_sel_t                         rd_sel,
    output csr_target_e                      wr_target,
    output logic                             commit,
    output counter_ctl_t [num_counters-1:0]  counter_ctl,
    output xlen_word_t                       mcountinhibit_q
);

    logic inhibit_cy;
    logic inhibit_ir;
    logic wr_legal;
    logic retire;

    function automatic csr_target_e decode(input csr_addr_t addr);
        case (addr)
            csr_addr_cycle:         decode = tgt_cycle;
            csr_addr_cycleh:        decode = tgt_cycleh;
            csr_addr_instret:       decode = tgt_instret;
            csr_addr_instreth:      decode = tgt_instreth;
            csr_addr_mcycle:        decode = tgt_mcycle;
            csr_addr_mcycleh:       decode = tgt_mcycleh;
            csr_addr_minstret:      decode = tgt_minstret;
            csr_addr_minstreth:     decode = tgt_minstreth;
            csr_addr_mhartid:       decode = tgt_mhartid;
            csr_addr_mstatus:       decode = tgt_mstatus;
            csr_addr_mstatush:      decode = tgt_mstatush;
            csr_addr_mtvec:         decode = tgt_mtvec;
            csr_addr_mip:           decode = tgt_mip;
            csr_addr_mie:           decode = tgt_mie;
            csr_addr_mcountinhibit: decode = tgt_mcountinhibit;
            csr_addr_mscratch:      decode = tgt_mscratch;
            csr_addr_mepc:          decode = tgt_mepc;
            csr_addr_mcause:        decode = tgt_mcause;
            csr_addr_mtval:         decode = tgt_mtval;
            default:                decode = tgt_none;
        endcase
    endfunction

    // user aliases are open to every mode, the rest need machine mode
    function automatic logic is_legal(input csr_target_e t, input priv_mode_e p);
        case (t)
            tgt_none:                                         is_legal = 1'b0;
            tgt_cycle, tgt_cycleh, tgt_instret, tgt_instreth: is_legal = 1'b1;
            default:                                          is_legal = (p == priv_machine);
        endcase
    endfunction

    assign rd_sel.target = decode(req.rd_addr);
    assign rd_sel.legal  = is_legal(rd_sel.target, priv);
    assign wr_target     = decode(req.wr_addr);
    assign wr_legal      = is_legal(wr_target, priv);
    assign commit        = req.wr_en && !stall_exec && !bubble_exec && wr_legal;
    assign retire        = !stall_exec && !bubble_exec;

    // only CY and IR are implemented
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
        end else if (commit && wr_target == tgt_mcountinhibit) begin
            inhibit_cy <= req.wr_data[0];
            inhibit_ir <= req.wr_data[2];
        end
    end

    assign mcountinhibit_q = {29'b0, inhibit_ir, 1'b0, inhibit_cy};

    ////////////////////////////////////////////////////////////
    // counter strobes
    always_comb begin
        counter_ctl[ctr_cycle].inc     = !inhibit_cy;
        counter_ctl[ctr_cycle].wr_lo   = commit && wr_target == tgt_mcycle;
        counter_ctl[ctr_cycle].wr_hi   = commit && wr_target == tgt_mcycleh;
        counter_ctl[ctr_instret].inc   = !inhibit_ir && retire;
        counter_ctl[ctr_instret].wr_lo = commit && wr_target == tgt_minstret;
        counter_ctl[ctr_instret].wr_hi = commit && wr_target == tgt_minstreth;
    end

endmodule

//--- source/csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] xlen_word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;

    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_machine = 2'd3
    } priv_mode_e;

    // decoded CSR, user aliases first
    typedef enum logic [4:0] {
        tgt_none, tgt_cycle, tgt_cycleh, tgt_instret, tgt_instreth,
        tgt_mcycle, tgt_mcycleh, tgt_minstret, tgt_minstreth,
        tgt_mhartid, tgt_mstatus, tgt_mstatush, tgt_mtvec, tgt_mip, tgt_mie,
        tgt_mcountinhibit, tgt_mscratch, tgt_mepc, tgt_mcause, tgt_mtval
    } csr_target_e;

    typedef struct packed {
        csr_addr_t  rd_addr;
        logic       wr_en;
        csr_addr_t  wr_addr;
        xlen_word_t wr_data;
    } csr_req_t;

    typedef struct packed {
        logic       insert;
        logic       is_mret;
        xlen_word_t epc;
        xlen_word_t cause;
        xlen_word_t val;
    } trap_req_t;

    typedef struct packed {
        csr_target_e target;
        logic        legal;
    } csr_sel_t;

    typedef struct packed {
        logic inc;
        logic wr_lo;
        logic wr_hi;
    } counter_ctl_t;

    // machine trap registers as seen by the read path
    typedef struct packed {
        xlen_word_t mstatus;
        xlen_word_t mtvec;
        xlen_word_t mip;
        xlen_word_t mie;
        xlen_word_t mscratch;
        xlen_word_t mepc;
        xlen_word_t mcause;
        xlen_word_t mtval;
    } mregs_t;

    localparam int num_counters = 2;
    localparam int ctr_cycle    = 0;
    localparam int ctr_instret  = 1;

    ////////////////////////////////////////////////////////////
    // standard CSR addresses
    localparam csr_addr_t csr_addr_cycle         = 12'hC00;
    localparam csr_addr_t csr_addr_instret       = 12'hC02;
    localparam csr_addr_t csr_addr_cycleh        = 12'hC80;
    localparam csr_addr_t csr_addr_instreth      = 12'hC82;
    localparam csr_addr_t csr_addr_mcycle        = 12'hB00;
    localparam csr_addr_t csr_addr_minstret      = 12'hB02;
    localparam csr_addr_t csr_addr_mcycleh       = 12'hB80;
    localparam csr_addr_t csr_addr_minstreth     = 12'hB82;
    localparam csr_addr_t csr_addr_mhartid       = 12'hF14;
    localparam csr_addr_t csr_addr_mstatus       = 12'h300;
    localparam csr_addr_t csr_addr_mie           = 12'h304;
    localparam csr_addr_t csr_addr_mtvec         = 12'h305;
    localparam csr_addr_t csr_addr_mstatush      = 12'h310;
    localparam csr_addr_t csr_addr_mcountinhibit = 12'h320;
    localparam csr_addr_t csr_addr_mscratch      = 12'h340;
    localparam csr_addr_t csr_addr_mepc          = 12'h341;
    localparam csr_addr_t csr_addr_mcause        = 12'h342;
    localparam csr_addr_t csr_addr_mtval         = 12'h343;
    localparam csr_addr_t csr_addr_mip           = 12'h344;

    localparam logic [1:0] mtvec_mode_direct   = 2'd0;
    localparam logic [1:0] mtvec_mode_vectored = 2'd1;

endpackage
